// File: Bender.yml
package:
  name: dual_mem_controller

sources:
  - include_dirs:
      - design
    files:
      - design/ram_bus_pkg.sv
      - design/mem_ctrl_pkg.sv
      - design/dual_enq_fifo.sv
      - design/write_buffer.sv
      - design/access_sequencer.sv
      - design/dual_mem_controller.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clock.sv
      - test/ram_model.sv
      - test/mem_ctrl_chk.sv
      - test/mem_ctrl_tb.sv

// File: compile.f
+incdir+design
design/ram_bus_pkg.sv
design/mem_ctrl_pkg.sv
design/dual_enq_fifo.sv
design/write_buffer.sv
design/access_sequencer.sv
design/dual_mem_controller.sv
test/tb_clock.sv
test/ram_model.sv
test/mem_ctrl_chk.sv
test/mem_ctrl_tb.sv

// File: design/access_sequencer.sv
////////////////////
// access sequencer
// picks one request at a time, runs the two ram beats,
// routes responses and holds the halt state
////////////////////
`timescale 1ns/10ps

module access_sequencer
    import ram_bus_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    input  logic            read_head_valid,
    input  read_entry_t     read_head,
    output logic            read_deq,
    input  logic            write_head_valid,
    input  write_entry_t    write_head,
    output logic            write_deq,
    input  logic            write_empty,
    output block_addr_t     search_addr,
    input  logic            fwd_hit,
    input  block_data_t     fwd_data,
    input  imem_req_t       imem_req0,
    input  imem_req_t       imem_req1,
    output imem_resp_t      imem_resp0,
    output imem_resp_t      imem_resp1,
    output dmem_read_resp_t read_resp0,
    output dmem_read_resp_t read_resp1,
    input  logic [1:0]      dcache_flushed,
    output ram_req_t        ram_req,
    input  ram_resp_t       ram_resp,
    output logic            mem_ctrl_flushed
);

    typedef enum logic [1:0] {
        ARBITRATE,
        BEAT0,
        BEAT1,
        HALT
    } seq_state_t;

    typedef enum logic [1:0] {
        OP_DREAD,
        OP_WRITE,
        OP_IREAD
    } op_t;

    // control half of the working request
    typedef struct packed {
        op_t  op;
        logic port;
    } work_ctrl_t;

    seq_state_t state;
    seq_state_t next_state;
    work_ctrl_t work;
    work_ctrl_t next_work;

    // payload half holds store data for writes and load data for reads
    block_addr_t work_addr;
    block_addr_t next_work_addr;
    block_data_t work_data;
    block_data_t next_work_data;

    // fetch port least recently served
    logic imem_lru;
    logic next_imem_lru;
    logic imem_pick;

    logic [1:0] resp_valid;
    logic [1:0] next_resp_valid;

    logic in_beat;
    logic word_sel;
    logic beat_done;
    logic fwd_skip;
    logic ihit_base;

    ////////////////////
    // ram side

    assign in_beat = (state == BEAT0) || (state == BEAT1);
    assign word_sel = (state == BEAT1);
    assign beat_done = in_beat && (ram_resp.state == ACCESS);

    // buffered write answers the read without touching the ram
    assign search_addr = work_addr;
    assign fwd_skip = (state == BEAT0) && (work.op == OP_DREAD) && fwd_hit;

    always_comb begin
        ram_req.addr = block_word_addr(work_addr, word_sel);
        ram_req.store = work_data[word_sel];
        ram_req.wen = in_beat && (work.op == OP_WRITE);
        ram_req.ren = in_beat && (work.op != OP_WRITE) && !fwd_skip;
    end

    ////////////////////
    // responses

    // fetch hit only if the port still wants this block
    assign ihit_base = (state == BEAT1) && beat_done && (work.op == OP_IREAD);

    always_comb begin
        imem_resp0.load = {ram_resp.load, work_data[0]};
        imem_resp1.load = {ram_resp.load, work_data[0]};
        imem_resp0.hit = ihit_base && !work.port && imem_req0.ren
            && (imem_req0.block_addr == work_addr);
        imem_resp1.hit = ihit_base && work.port && imem_req1.ren
            && (imem_req1.block_addr == work_addr);
    end

    // data holds steady while the registered valid is up
    assign read_resp0.valid = resp_valid[0];
    assign read_resp0.data = work_data;
    assign read_resp1.valid = resp_valid[1];
    assign read_resp1.data = work_data;

    ////////////////////
    // next state

    // lru decides when both ports ask
    assign imem_pick = (imem_req0.ren && imem_req1.ren) ? imem_lru : imem_req1.ren;

    always_comb begin
        next_state = state;
        next_work = work;
        next_work_addr = work_addr;
        next_work_data = work_data;
        next_imem_lru = imem_lru;
        next_resp_valid = 2'b00;
        read_deq = 1'b0;
        write_deq = 1'b0;
        case (state)
            ARBITRATE: begin
                // halt beats any pending request
                if ((&dcache_flushed) && write_empty) begin
                    next_state = HALT;
                end else if (read_head_valid) begin
                    read_deq = 1'b1;
                    next_work = '{op: OP_DREAD, port: read_head.port};
                    next_work_addr = read_head.block_addr;
                    next_state = BEAT0;
                end else if (write_head_valid) begin
                    write_deq = 1'b1;
                    next_work = '{op: OP_WRITE, port: 1'b0};
                    next_work_addr = write_head.block_addr;
                    next_work_data = write_head.data;
                    next_state = BEAT0;
                end else if (imem_req0.ren || imem_req1.ren) begin
                    next_work = '{op: OP_IREAD, port: imem_pick};
                    next_work_addr = imem_pick ? imem_req1.block_addr : imem_req0.block_addr;
                    next_imem_lru = !imem_pick;
                    next_state = BEAT0;
                end
            end
            BEAT0: begin
                if (fwd_skip) begin
                    next_work_data = fwd_data;
                    next_resp_valid[work.port] = 1'b1;
                    next_state = ARBITRATE;
                end else if (beat_done) begin
                    // keep store data intact for a write
                    if (work.op != OP_WRITE) begin
                        next_work_data[0] = ram_resp.load;
                    end
                    next_state = BEAT1;
                end
            end
            BEAT1: begin
                if (beat_done) begin
                    if (work.op != OP_WRITE) begin
                        next_work_data[1] = ram_resp.load;
                    end
                    if (work.op == OP_DREAD) begin
                        next_resp_valid[work.port] = 1'b1;
                    end
                    next_state = ARBITRATE;
                end
            end
            default: begin
                // no way out until reset
                next_state = HALT;
            end
        endcase
    end

    ////////////////////
    // registers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= ARBITRATE;
            work <= '{op: OP_DREAD, port: 1'b0};
            imem_lru <= 1'b0;
            resp_valid <= 2'b00;
            mem_ctrl_flushed <= 1'b0;
        end else begin
            state <= next_state;
            work <= next_work;
            imem_lru <= next_imem_lru;
            resp_valid <= next_resp_valid;
            // one cycle behind entering halt
            mem_ctrl_flushed <= (state == HALT);
        end
    end

    always_ff @(posedge CLK) begin
        work_addr <= next_work_addr;
        work_data <= next_work_data;
    end

endmodule

// File: design/dual_enq_fifo.sv
////////////////////
// dual enqueue fifo
// ring queue taking up to two entries a cycle,
// port 0 first, and releasing one at the head
////////////////////
`timescale 1ns/10ps

module dual_enq_fifo #(
    parameter type ENTRY_T = logic,
    parameter int  DEPTH   = 8
) (
    input  logic   CLK,
    input  logic   nRST,
    input  logic   enq0_valid,
    input  logic   enq1_valid,
    input  ENTRY_T enq0_entry,
    input  ENTRY_T enq1_entry,
    output logic   head_valid,
    output ENTRY_T head_entry,
    input  logic   deq
);

    localparam int IW = $clog2(DEPTH);

    // top bit of each pointer is the wrap bit
    logic [IW:0] head_ptr;
    logic [IW:0] tail_ptr;

    // slot for port 1
    logic [IW-1:0] enq1_idx;

    ENTRY_T ring [DEPTH];

    // port 1 goes right after port 0
    // or takes the tail itself when port 0 is quiet
    assign enq1_idx = tail_ptr[IW-1:0] + IW'(enq0_valid);

    // head equals tail only when empty, thanks to the wrap bit
    assign head_valid = (head_ptr != tail_ptr);
    assign head_entry = ring[head_ptr[IW-1:0]];

    ////////////////////
    // pointers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            // advance by the number of enqueues
            tail_ptr <= tail_ptr + (IW+1)'(enq0_valid) + (IW+1)'(enq1_valid);
            if (deq) begin
                head_ptr <= head_ptr + (IW+1)'(1);
            end
        end
    end

    ////////////////////
    // storage

    always_ff @(posedge CLK) begin
        if (enq0_valid) begin
            ring[tail_ptr[IW-1:0]] <= enq0_entry;
        end
        if (enq1_valid) begin
            ring[enq1_idx] <= enq1_entry;
        end
    end

endmodule

// File: design/dual_mem_controller.sv
////////////////////
// dual core memory controller
// read queue, write buffer and access sequencer
// in front of one single-ported ram
////////////////////
`timescale 1ns/10ps
`include "mem_ctrl_consts.svh"

module dual_mem_controller
    import ram_bus_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    output ram_req_t        ram_req,
    input  ram_resp_t       ram_resp,
    input  imem_req_t       imem_req0,
    input  imem_req_t       imem_req1,
    output imem_resp_t      imem_resp0,
    output imem_resp_t      imem_resp1,
    input  dmem_read_req_t  dmem_read_req0,
    input  dmem_read_req_t  dmem_read_req1,
    output dmem_read_resp_t dmem_read_resp0,
    output dmem_read_resp_t dmem_read_resp1,
    input  dmem_write_req_t dmem_write_req0,
    input  dmem_write_req_t dmem_write_req1,
    output logic            write_slow_down,
    input  logic [1:0]      dcache_flushed,
    output logic            mem_ctrl_flushed
);

    // read queue
    read_entry_t read_entry0;
    read_entry_t read_entry1;
    read_entry_t read_head;
    logic        read_head_valid;
    logic        read_deq;

    // write buffer
    write_entry_t write_head;
    logic         write_head_valid;
    logic         write_deq;
    logic         write_empty;

    // forwarding search
    block_addr_t search_addr;
    logic        fwd_hit;
    block_data_t fwd_data;

    // tag each read with the port it came from
    assign read_entry0 = '{block_addr: dmem_read_req0.block_addr, port: 1'b0};
    assign read_entry1 = '{block_addr: dmem_read_req1.block_addr, port: 1'b1};

    dual_enq_fifo #(
        .ENTRY_T (read_entry_t),
        .DEPTH   (`READ_QUEUE_DEPTH)
    ) read_queue_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .enq0_valid (dmem_read_req0.valid),
        .enq1_valid (dmem_read_req1.valid),
        .enq0_entry (read_entry0),
        .enq1_entry (read_entry1),
        .head_valid (read_head_valid),
        .head_entry (read_head),
        .deq        (read_deq)
    );

    write_buffer write_buffer_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .write_req0  (dmem_write_req0),
        .write_req1  (dmem_write_req1),
        .slow_down   (write_slow_down),
        .empty       (write_empty),
        .head_valid  (write_head_valid),
        .head_entry  (write_head),
        .deq         (write_deq),
        .search_addr (search_addr),
        .fwd_hit     (fwd_hit),
        .fwd_data    (fwd_data)
    );

    access_sequencer access_sequencer_i (
        .CLK              (CLK),
        .nRST             (nRST),
        .read_head_valid  (read_head_valid),
        .read_head        (read_head),
        .read_deq         (read_deq),
        .write_head_valid (write_head_valid),
        .write_head       (write_head),
        .write_deq        (write_deq),
        .write_empty      (write_empty),
        .search_addr      (search_addr),
        .fwd_hit          (fwd_hit),
        .fwd_data         (fwd_data),
        .imem_req0        (imem_req0),
        .imem_req1        (imem_req1),
        .imem_resp0       (imem_resp0),
        .imem_resp1       (imem_resp1),
        .read_resp0       (dmem_read_resp0),
        .read_resp1       (dmem_read_resp1),
        .dcache_flushed   (dcache_flushed),
        .ram_req          (ram_req),
        .ram_resp         (ram_resp),
        .mem_ctrl_flushed (mem_ctrl_flushed)
    );

endmodule

// File: design/mem_ctrl_consts.svh
////////////////////
// memory controller constants
// word and address widths, queue depths
// and the write pressure threshold
////////////////////
`ifndef MEM_CTRL_CONSTS_SVH
`define MEM_CTRL_CONSTS_SVH

// bits per ram word
`define WORD_WIDTH 32

// block address bits
`define BLOCK_ADDR_WIDTH 13

// zero bits above the block address in a byte address
`define RAM_ADDR_PAD_WIDTH 16

// queue depths, kept at powers of two
`define READ_QUEUE_DEPTH 8
`define WRITE_BUFFER_DEPTH 8

// slow-down once more writes than this are waiting
`define SLOW_DOWN_THRESHOLD 6

`endif

// File: design/mem_ctrl_pkg.sv
////////////////////
// cache side types
// fetch, data read and data write ports, queue entries
////////////////////
`include "mem_ctrl_consts.svh"

package mem_ctrl_pkg;
    import ram_bus_pkg::*;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`BLOCK_ADDR_WIDTH-1:0] block_addr_t;

    // word 0 sits in the low half
    typedef word_t [1:0] block_data_t;

    ////////////////////
    // instruction fetch

    // level request held by the icache
    typedef struct packed {
        logic        ren;
        block_addr_t block_addr;
    } imem_req_t;

    typedef struct packed {
        logic        hit;
        block_data_t load;
    } imem_resp_t;

    ////////////////////
    // data ports

    // one pulse per read
    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
    } dmem_read_req_t;

    typedef struct packed {
        logic        valid;
        block_data_t data;
    } dmem_read_resp_t;

    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
        block_data_t data;
    } dmem_write_req_t;

    ////////////////////
    // queue entries

    // port remembers where the response goes
    typedef struct packed {
        block_addr_t block_addr;
        logic        port;
    } read_entry_t;

    typedef struct packed {
        block_addr_t block_addr;
        block_data_t data;
    } write_entry_t;

    // byte address of one word in a block
    function automatic ram_addr_t block_word_addr(block_addr_t block_addr, logic word_sel);
        ram_addr_t addr;
        addr = '0;
        addr.block_addr = block_addr;
        addr.word_sel = word_sel;
        return addr;
    endfunction

endpackage

// File: design/ram_bus_pkg.sv
////////////////////
// ram bus types
// status, byte address layout, request and response
////////////////////
`include "mem_ctrl_consts.svh"

package ram_bus_pkg;

    // status the ram reports every cycle
    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ram_state_t;

    // byte address split into its fields
    typedef struct packed {
        logic [`RAM_ADDR_PAD_WIDTH-1:0] pad;
        logic [`BLOCK_ADDR_WIDTH-1:0]   block_addr;
        logic                           word_sel;
        logic [1:0]                     byte_offset;
    } ram_addr_t;

    // one beat toward the ram
    typedef struct packed {
        logic                   ren;
        logic                   wen;
        ram_addr_t              addr;
        logic [`WORD_WIDTH-1:0] store;
    } ram_req_t;

    typedef struct packed {
        ram_state_t             state;
        logic [`WORD_WIDTH-1:0] load;
    } ram_resp_t;

endpackage

// File: design/write_buffer.sv
////////////////////
// write buffer
// shared by both data ports, two writes per cycle,
// slow-down on high occupancy, youngest-match forwarding
////////////////////
`timescale 1ns/10ps
`include "mem_ctrl_consts.svh"

module write_buffer
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    input  dmem_write_req_t write_req0,
    input  dmem_write_req_t write_req1,
    output logic            slow_down,
    output logic            empty,
    output logic            head_valid,
    output write_entry_t    head_entry,
    input  logic            deq,
    input  block_addr_t     search_addr,
    output logic            fwd_hit,
    output block_data_t     fwd_data
);

    localparam int DEPTH = `WRITE_BUFFER_DEPTH;
    localparam int IW = $clog2(DEPTH);

    // wrap bit on top of each pointer
    logic [IW:0] head_ptr;
    logic [IW:0] tail_ptr;
    logic [IW:0] occupancy;
    logic [IW-1:0] enq1_idx;

    write_entry_t ring [DEPTH];

    assign occupancy = tail_ptr - head_ptr;
    assign empty = (head_ptr == tail_ptr);
    assign head_valid = !empty;
    assign head_entry = ring[head_ptr[IW-1:0]];

    // advisory only, the caches stop sending while high
    assign slow_down = (occupancy > (IW+1)'(`SLOW_DOWN_THRESHOLD));

    // port 1 follows port 0 in age
    assign enq1_idx = tail_ptr[IW-1:0] + IW'(write_req0.valid);

    ////////////////////
    // pointers

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            tail_ptr <= tail_ptr + (IW+1)'(write_req0.valid) + (IW+1)'(write_req1.valid);
            if (deq) begin
                head_ptr <= head_ptr + (IW+1)'(1);
            end
        end
    end

    ////////////////////
    // storage

    always_ff @(posedge CLK) begin
        if (write_req0.valid) begin
            ring[tail_ptr[IW-1:0]] <= '{
                block_addr: write_req0.block_addr,
                data:       write_req0.data
            };
        end
        if (write_req1.valid) begin
            ring[enq1_idx] <= '{
                block_addr: write_req1.block_addr,
                data:       write_req1.data
            };
        end
    end

    ////////////////////
    // forwarding search

    // walk from head toward tail
    // later matches overwrite earlier ones, so the youngest wins
    always_comb begin
        logic [IW-1:0] slot;
        fwd_hit = 1'b0;
        fwd_data = '0;
        for (int d = 0; d < DEPTH; d++) begin
            slot = head_ptr[IW-1:0] + IW'(d);
            // only slots between head and tail hold live writes
            if (((IW+1)'(d) < occupancy) && (ring[slot].block_addr == search_addr)) begin
                fwd_hit = 1'b1;
                fwd_data = ring[slot].data;
            end
        end
    end

endmodule

// File: test/mem_ctrl_chk.sv
////////////////////
// memory controller protocol checker
// ram direction, sticky flushed, quiet outputs in reset
////////////////////
`timescale 1ns/10ps

module mem_ctrl_chk
    import ram_bus_pkg::*;
    import mem_ctrl_pkg::*;
(
    input logic            CLK,
    input logic            nRST,
    input ram_req_t        ram_req,
    input imem_resp_t      imem_resp0,
    input imem_resp_t      imem_resp1,
    input dmem_read_resp_t dmem_read_resp0,
    input dmem_read_resp_t dmem_read_resp1,
    input logic            write_slow_down,
    input logic            mem_ctrl_flushed
);

    // assertion failures so far
    int fail_count = 0;

    // one direction per beat
    ram_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(ram_req.ren && ram_req.wen))
    else begin
        fail_count++;
        $error("ram read enable and write enable high together");
    end

    // halt is for good
    flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        mem_ctrl_flushed |=> mem_ctrl_flushed)
    else begin
        fail_count++;
        $error("mem_ctrl_flushed fell after rising");
    end

    ////////////////////
    // reset

    resp_quiet: assert property (@(posedge CLK) !nRST |-> !(dmem_read_resp0.valid
        || dmem_read_resp1.valid || imem_resp0.hit || imem_resp1.hit))
    else begin
        fail_count++;
        $error("response valid or fetch hit high during reset");
    end

    ctrl_quiet: assert property (@(posedge CLK) !nRST |-> !(ram_req.ren || ram_req.wen
        || write_slow_down || mem_ctrl_flushed))
    else begin
        fail_count++;
        $error("ram enable, slow-down or flushed high during reset");
    end

endmodule

bind dual_mem_controller mem_ctrl_chk chk_i (.*);

// File: test/mem_ctrl_tb.sv
////////////////////
// memory controller testbench
// mirror memory, per-port expected queues,
// fetch alternation, slow-down and halt
////////////////////
`timescale 1ns/10ps
`include "mem_ctrl_consts.svh"

module mem_ctrl_tb
    import ram_bus_pkg::*;
    import mem_ctrl_pkg::*;
();

    // 200 requests at 20 cycles each
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int BLOCKS = 2**`BLOCK_ADDR_WIDTH;
    localparam int FETCH_HITS = 20;

    logic            CLK;
    logic            nRST;
    ram_req_t        ram_req;
    ram_resp_t       ram_resp;
    imem_req_t       imem_req0;
    imem_req_t       imem_req1;
    imem_resp_t      imem_resp0;
    imem_resp_t      imem_resp1;
    dmem_read_req_t  dmem_read_req0;
    dmem_read_req_t  dmem_read_req1;
    dmem_read_resp_t dmem_read_resp0;
    dmem_read_resp_t dmem_read_resp1;
    dmem_write_req_t dmem_write_req0;
    dmem_write_req_t dmem_write_req1;
    logic            write_slow_down;
    logic [1:0]      dcache_flushed;
    logic            mem_ctrl_flushed;

    integer seed = 32'h4482_a0d7;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // writes enqueued but not yet dequeued
    int pending = 0;
    logic slow_seen = 1'b0;

    // fetch bookkeeping
    int ihits = 0;
    logic have_ihit = 1'b0;
    logic last_ihit_port = 1'b0;
    logic [1:0] ihit_flag = 2'b00;

    block_data_t mirror [BLOCKS];
    block_data_t exp_q0 [$];
    block_data_t exp_q1 [$];

    tb_clock clock_i (
        .CLK  (CLK),
        .nRST (nRST)
    );

    ram_model ram_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .ram_req  (ram_req),
        .ram_resp (ram_resp)
    );

    dual_mem_controller dut_i (.*);

    ////////////////////
    // stimulus helpers

    // next cycle, pulses from the last one dropped
    task automatic step();
        @(posedge CLK);
        #1;
        dmem_read_req0.valid = 1'b0;
        dmem_read_req1.valid = 1'b0;
        dmem_write_req0.valid = 1'b0;
        dmem_write_req1.valid = 1'b0;
    endtask

    function automatic block_data_t random_block();
        block_data_t b;
        b[0] = $random(seed);
        b[1] = $random(seed);
        return b;
    endfunction

    function automatic block_addr_t fetch_addr();
        // written blocks 16..31 and untouched ones above
        return block_addr_t'(16 + ($unsigned($random(seed)) % 48));
    endfunction

    // mirror follows the enqueue order, port 1 is younger
    task automatic issue_write(input logic port, input block_addr_t addr);
        dmem_write_req_t req;
        req = '{valid: 1'b1, block_addr: addr, data: random_block()};
        if (port) begin
            dmem_write_req1 = req;
        end else begin
            dmem_write_req0 = req;
        end
        mirror[addr] = req.data;
    endtask

    task automatic issue_read(input logic port, input block_addr_t addr);
        if (port) begin
            dmem_read_req1 = '{valid: 1'b1, block_addr: addr};
            exp_q1.push_back(mirror[addr]);
        end else begin
            dmem_read_req0 = '{valid: 1'b1, block_addr: addr};
            exp_q0.push_back(mirror[addr]);
        end
    endtask

    // hold off while slow-down is up
    task automatic write_pair(input block_addr_t addr0, input block_addr_t addr1);
        step();
        while (write_slow_down) begin
            step();
        end
        issue_write(1'b0, addr0);
        issue_write(1'b1, addr1);
    endtask

    // no back-pressure on reads, so keep the read queue from overflowing
    task automatic read_pair(input block_addr_t addr0, input block_addr_t addr1);
        step();
        while (exp_q0.size() + exp_q1.size() > `READ_QUEUE_DEPTH - 2) begin
            step();
        end
        issue_read(1'b0, addr0);
        issue_read(1'b1, addr1);
    endtask

    task automatic wait_idle();
        while (exp_q0.size() != 0 || exp_q1.size() != 0 || pending != 0) begin
            step();
        end
    endtask

    ////////////////////
    // response checks

    task automatic check_read(input logic port, input block_data_t data);
        block_data_t expected;
        checks++;
        if ((port && exp_q1.size() == 0) || (!port && exp_q0.size() == 0)) begin
            errors++;
            $display("data port %0d answered a read that was never sent (time %0t)",
                port, $time);
        end else begin
            expected = port ? exp_q1.pop_front() : exp_q0.pop_front();
            assert (data == expected) else begin
                errors++;
                $display("CHECK FAILED at %0t: data port %0d read %h, expected %h",
                    $time, port, data, expected);
            end
        end
    endtask

    task automatic check_fetch();
        logic        port;
        block_addr_t addr;
        block_data_t load;
        checks++;
        if (imem_resp0.hit && imem_resp1.hit) begin
            errors++;
            $display("both fetch ports hit in the same cycle (time %0t)", $time);
        end
        port = imem_resp1.hit;
        addr = port ? imem_req1.block_addr : imem_req0.block_addr;
        load = port ? imem_resp1.load : imem_resp0.load;
        assert (load == mirror[addr]) else begin
            errors++;
            $display("CHECK FAILED at %0t: fetch port %0d block %0d loaded %h, expected %h",
                $time, port, addr, load, mirror[addr]);
        end
        // both ports ask all the time, so service alternates
        assert (!have_ihit || port != last_ihit_port) else begin
            errors++;
            $display("CHECK FAILED at %0t: fetch port %0d served twice in a row",
                $time, port);
        end
        have_ihit = 1'b1;
        last_ihit_port = port;
        ihit_flag[port] = 1'b1;
        ihits++;
    endtask

    // outputs settled half a cycle after the edge
    always @(negedge CLK) begin
        if (nRST) begin
            checks++;
            assert (write_slow_down == (pending > `SLOW_DOWN_THRESHOLD)) else begin
                errors++;
                $display("CHECK FAILED at %0t: write_slow_down %b with %0d writes unserved",
                    $time, write_slow_down, pending);
            end
            if (write_slow_down) begin
                slow_seen = 1'b1;
            end
            if (dmem_read_resp0.valid) begin
                check_read(1'b0, dmem_read_resp0.data);
            end
            if (dmem_read_resp1.valid) begin
                check_read(1'b1, dmem_read_resp1.data);
            end
            if (imem_resp0.hit || imem_resp1.hit) begin
                check_fetch();
            end
            // count for the coming edge
            pending = pending + int'(dmem_write_req0.valid) + int'(dmem_write_req1.valid)
                - int'(dut_i.write_deq);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("checks: %0d, testbench errors: %0d, assertion errors: %0d",
                checks, errors, dut_i.chk_i.fail_count);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////
    // test sequence

    initial begin
        imem_req0 = '0;
        imem_req1 = '0;
        dmem_read_req0 = '0;
        dmem_read_req1 = '0;
        dmem_write_req0 = '0;
        dmem_write_req1 = '0;
        dcache_flushed = 2'b00;
        // unwritten words hold their own byte address
        for (int b = 0; b < BLOCKS; b++) begin
            mirror[b][0] = `WORD_WIDTH'(b) << 3;
            mirror[b][1] = (`WORD_WIDTH'(b) << 3) | `WORD_WIDTH'(4);
        end
        wait (nRST);

        // write pairs, swapped reads right behind them
        // round 3 hits one block from both ports
        for (int i = 0; i < 8; i++) begin
            write_pair(block_addr_t'(16 + 2*i), block_addr_t'(i == 3 ? 16 + 2*i : 17 + 2*i));
            read_pair(block_addr_t'(i == 3 ? 16 + 2*i : 17 + 2*i), block_addr_t'(16 + 2*i));
        end
        wait_idle();

        // same blocks again, now from the ram
        for (int i = 0; i < 8; i++) begin
            read_pair(block_addr_t'(16 + 2*i), block_addr_t'(17 + 2*i));
        end
        wait_idle();

        // both fetch ports asking, new block after each hit
        step();
        imem_req0 = '{ren: 1'b1, block_addr: fetch_addr()};
        imem_req1 = '{ren: 1'b1, block_addr: fetch_addr()};
        while (ihits < FETCH_HITS) begin
            step();
            if (ihit_flag[0]) begin
                imem_req0.block_addr = fetch_addr();
                ihit_flag[0] = 1'b0;
            end
            if (ihit_flag[1]) begin
                imem_req1.block_addr = fetch_addr();
                ihit_flag[1] = 1'b0;
            end
        end
        imem_req0.ren = 1'b0;
        imem_req1.ren = 1'b0;

        // write burst faster than the ram drains it
        for (int i = 0; i < 16; i++) begin
            write_pair(block_addr_t'(64 + 2*i), block_addr_t'(65 + 2*i));
        end
        wait_idle();
        if (!slow_seen) begin
            errors++;
            $display("write_slow_down never rose during the write burst");
        end
        // nothing lost on the way
        for (int i = 0; i < 16; i++) begin
            read_pair(block_addr_t'(65 + 2*i), block_addr_t'(64 + 2*i));
        end
        wait_idle();

        // halt
        dcache_flushed = 2'b11;
        while (!mem_ctrl_flushed) begin
            step();
        end
        repeat (20) step();
        checks++;
        assert (mem_ctrl_flushed) else begin
            errors++;
            $display("CHECK FAILED at %0t: mem_ctrl_flushed fell after rising", $time);
        end

        $display("checks: %0d, testbench errors: %0d, assertion errors: %0d",
            checks, errors, dut_i.chk_i.fail_count);
        if (errors + dut_i.chk_i.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: test/ram_model.sv
////////////////////
// behavioral ram
// single port, 0 to 3 random wait states per beat,
// unwritten words read back as their own byte address
////////////////////
`timescale 1ns/10ps
`include "mem_ctrl_consts.svh"

module ram_model
    import ram_bus_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  ram_req_t  ram_req,
    output ram_resp_t ram_resp
);

    // block address plus word select
    localparam int IDX_W = `BLOCK_ADDR_WIDTH + 1;

    integer seed = 32'h4482_a0d7;

    logic [`WORD_WIDTH-1:0] mem [2**IDX_W];
    logic [IDX_W-1:0]       idx;
    logic [1:0]             wait_left;
    logic                   active;

    // pad and byte offset are zero, so byte address is idx times 4
    initial begin
        for (int i = 0; i < 2**IDX_W; i++) begin
            mem[i] = `WORD_WIDTH'(i) << 2;
        end
    end

    assign idx = {ram_req.addr.block_addr, ram_req.addr.word_sel};
    assign active = ram_req.ren || ram_req.wen;

    always_comb begin
        ram_resp.load = mem[idx];
        if (!active) begin
            ram_resp.state = FREE;
        end else if (wait_left == 2'd0) begin
            ram_resp.state = ACCESS;
        end else begin
            ram_resp.state = BUSY;
        end
    end

    ////////////////////
    // wait states and writes

    // new wait count drawn for the beat after each access
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_left <= 2'($random(seed));
        end else if (active) begin
            if (wait_left == 2'd0) begin
                wait_left <= 2'($random(seed));
                if (ram_req.wen) begin
                    mem[idx] <= ram_req.store;
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

endmodule

// File: test/tb_clock.sv
////////////////////
// testbench clock and reset
// 10 ns clock, reset held low for a few cycles
////////////////////
`timescale 1ns/10ps

module tb_clock #(
    parameter int RESET_CYCLES = 10
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
    end

endmodule
